// ==== verilog/siq_cfg_pkg.sv ====
`default_nettype none

package siq_cfg_pkg;

    localparam int PREG_W = 7;
    localparam int XLEN = 32;
    localparam int ROB_W = 6;
    localparam int SQ_W = 4;

    // the wrap bit flips each time the ROB index rolls over.
    typedef struct packed {
        logic dir;
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        MEMOP_SB = 2'd0,
        MEMOP_SH = 2'd1,
        MEMOP_SW = 2'd2
    } memop_t;

    // true when rob sits after the redirect point in program order.
    function automatic logic rob_younger(rob_idx_t rob, rob_idx_t redir);
        return (rob.dir ^ redir.dir) ^ (rob.idx > redir.idx);
    endfunction

    function automatic logic [1:0] size_of_memop(memop_t op);
        case (op)
            MEMOP_SB: return 2'd0;
            MEMOP_SH: return 2'd1;
            default:  return 2'd2;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/siq_msg_pkg.sv ====
`default_nettype none

package siq_msg_pkg;

    // wide enough for a full flush of a 16-entry bank.
    localparam int CREDIT_W = 5;

    typedef struct packed {
        logic valid;
        logic [siq_cfg_pkg::PREG_W-1:0] rs1;
        logic rs1_rdy;
        logic [siq_cfg_pkg::PREG_W-1:0] rs2;
        logic rs2_rdy;
        siq_cfg_pkg::rob_idx_t rob;
        logic [siq_cfg_pkg::SQ_W-1:0] sq_idx;
        siq_cfg_pkg::memop_t memop;
        logic [11:0] imm;
    } siq_dispatch_t;

    typedef struct packed {
        logic valid;
        logic [siq_cfg_pkg::PREG_W-1:0] preg;
    } siq_wakeup_t;

    typedef struct packed {
        logic valid;
        siq_cfg_pkg::rob_idx_t rob;
    } siq_redirect_t;

    typedef struct packed {
        logic [CREDIT_W-1:0] addr_freed;
        logic [CREDIT_W-1:0] data_freed;
    } siq_credit_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [siq_cfg_pkg::SQ_W-1:0] sq_idx;
        siq_cfg_pkg::memop_t memop;
    } siq_addr_payload_t;

    typedef struct packed {
        logic [siq_cfg_pkg::SQ_W-1:0] sq_idx;
        logic [1:0] size;
    } siq_data_payload_t;

    typedef struct packed {
        logic valid;
        siq_cfg_pkg::rob_idx_t rob;
        logic [siq_cfg_pkg::SQ_W-1:0] sq_idx;
        logic [siq_cfg_pkg::XLEN-1:0] base;
        logic [11:0] imm;
        siq_cfg_pkg::memop_t memop;
    } siq_addr_uop_t;

    typedef struct packed {
        logic valid;
        siq_cfg_pkg::rob_idx_t rob;
        logic [siq_cfg_pkg::SQ_W-1:0] sq_idx;
        logic [siq_cfg_pkg::XLEN-1:0] value;
        logic [1:0] size;
    } siq_data_uop_t;

endpackage

`default_nettype wire

// ==== verilog/store_entry_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_entry_bank #(
    parameter int DEPTH = 8,
    parameter int WB_PORTS = 2,
    parameter type payload_t = logic
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      alloc_i,
    input  logic [siq_cfg_pkg::PREG_W-1:0]            src_preg_i,
    input  logic                                      src_rdy_i,
    input  siq_cfg_pkg::rob_idx_t                     rob_i,
    input  payload_t                                  payload_i,
    input  siq_msg_pkg::siq_wakeup_t [WB_PORTS-1:0]   wakeup_i,
    input  siq_msg_pkg::siq_redirect_t                redirect_i,
    output logic                                      sel_valid_o,
    output logic [siq_cfg_pkg::PREG_W-1:0]            sel_preg_o,
    output siq_cfg_pkg::rob_idx_t                     sel_rob_o,
    output payload_t                                  sel_payload_o,
    output logic [$clog2(DEPTH):0]                    freed_cnt_o
);
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = IDX_W + 1;

    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] valid_d;
    logic [DEPTH-1:0] rdy_q;
    logic [DEPTH-1:0] rdy_d;
    logic [siq_cfg_pkg::PREG_W-1:0] preg_q [DEPTH];
    siq_cfg_pkg::rob_idx_t rob_q [DEPTH];
    payload_t payload_q [DEPTH];

    logic [DEPTH-1:0] alloc_mask;
    logic [DEPTH-1:0] flush_mask;
    logic [DEPTH-1:0] free_mask;
    logic [DEPTH-1:0] wake_hit;
    logic [DEPTH-1:0] pickable;
    logic [IDX_W-1:0] alloc_idx;
    logic [IDX_W-1:0] pick_idx;
    logic             pick_any;
    logic             new_rdy;
    logic             sel_valid_q;
    logic [IDX_W-1:0] sel_idx_q;

    always_comb begin
        alloc_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_idx = IDX_W'(i);
            end
        end
        alloc_mask = '0;
        if (alloc_i) begin
            alloc_mask[alloc_idx] = 1'b1;
        end
    end

    // a wakeup in the dispatch cycle also counts for the incoming store.
    always_comb begin
        wake_hit = '0;
        new_rdy = src_rdy_i;
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wakeup_i[p].valid) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (wakeup_i[p].preg == preg_q[i]) begin
                        wake_hit[i] = 1'b1;
                    end
                end
                if (wakeup_i[p].preg == src_preg_i) begin
                    new_rdy = 1'b1;
                end
            end
        end
    end

    // the entry held in the select register leaves at the next edge.
    always_comb begin
        pickable = valid_q & rdy_q;
        if (sel_valid_q) begin
            pickable[sel_idx_q] = 1'b0;
        end
        pick_any = (|pickable) && !redirect_i.valid;
        pick_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (pickable[i]) begin
                pick_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            flush_mask[i] = redirect_i.valid &&
                            siq_cfg_pkg::rob_younger(rob_q[i], redirect_i.rob);
        end
        free_mask = '0;
        if (sel_valid_q) begin
            free_mask[sel_idx_q] = 1'b1;
        end
        valid_d = (valid_q & ~flush_mask & ~free_mask) | alloc_mask;
        for (int i = 0; i < DEPTH; i++) begin
            rdy_d[i] = alloc_mask[i] ? new_rdy : (rdy_q[i] | wake_hit[i]);
        end
    end

    always_comb begin
        freed_cnt_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            freed_cnt_o = freed_cnt_o + CNT_W'(valid_q[i] & ~valid_d[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            rdy_q <= '0;
            sel_valid_q <= 1'b0;
            sel_idx_q <= '0;
        end else begin
            valid_q <= valid_d;
            rdy_q <= rdy_d;
            sel_valid_q <= pick_any;
            if (pick_any) begin
                sel_idx_q <= pick_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            preg_q[alloc_idx] <= src_preg_i;
            rob_q[alloc_idx] <= rob_i;
            payload_q[alloc_idx] <= payload_i;
        end
    end

    assign sel_valid_o = sel_valid_q;
    assign sel_preg_o = preg_q[sel_idx_q];
    assign sel_rob_o = rob_q[sel_idx_q];
    assign sel_payload_o = payload_q[sel_idx_q];

    // the dispatcher must hold a credit for this bank.
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc_i |-> !(&valid_q));

    a_sel_entry_valid: assert property (@(posedge clk) disable iff (rst)
        sel_valid_q |-> valid_q[sel_idx_q]);

endmodule

`default_nettype wire

// ==== verilog/store_issue_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_issue_pipe #(
    parameter type payload_t = logic
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            sel_valid_i,
    input  logic [siq_cfg_pkg::PREG_W-1:0]  sel_preg_i,
    input  siq_cfg_pkg::rob_idx_t           sel_rob_i,
    input  payload_t                        sel_payload_i,
    input  siq_msg_pkg::siq_redirect_t      redirect_i,
    output logic [siq_cfg_pkg::PREG_W-1:0]  rf_preg_o,
    input  logic [siq_cfg_pkg::XLEN-1:0]    rf_val_i,
    output logic                            valid_o,
    output siq_cfg_pkg::rob_idx_t           rob_o,
    output logic [siq_cfg_pkg::XLEN-1:0]    val_o,
    output payload_t                        payload_o
);
    logic                           s1_valid_q;
    logic [siq_cfg_pkg::PREG_W-1:0] s1_preg_q;
    siq_cfg_pkg::rob_idx_t          s1_rob_q;
    payload_t                       s1_payload_q;
    logic                           s2_valid_q;
    siq_cfg_pkg::rob_idx_t          s2_rob_q;
    logic [siq_cfg_pkg::XLEN-1:0]   s2_val_q;
    payload_t                       s2_payload_q;
    logic                           sel_kill;
    logic                           s1_kill;

    assign sel_kill = redirect_i.valid && siq_cfg_pkg::rob_younger(sel_rob_i, redirect_i.rob);
    assign s1_kill = redirect_i.valid && siq_cfg_pkg::rob_younger(s1_rob_q, redirect_i.rob);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= sel_valid_i && !sel_kill;
            s2_valid_q <= s1_valid_q && !s1_kill;
        end
    end

    // the register file answers in the cycle the stage-1 tag is presented.
    always_ff @(posedge clk) begin
        s1_preg_q <= sel_preg_i;
        s1_rob_q <= sel_rob_i;
        s1_payload_q <= sel_payload_i;
        s2_rob_q <= s1_rob_q;
        s2_val_q <= rf_val_i;
        s2_payload_q <= s1_payload_q;
    end

    assign rf_preg_o = s1_preg_q;
    assign valid_o = s2_valid_q;
    assign rob_o = s2_rob_q;
    assign val_o = s2_val_q;
    assign payload_o = s2_payload_q;

    // the bank selects nothing in a redirect cycle, so no unchecked uop follows it.
    a_no_sel_after_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect_i.valid |=> !sel_valid_i);

endmodule

`default_nettype wire

// ==== verilog/store_issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_issue_queue #(
    parameter int DEPTH = 8,
    parameter int WB_PORTS = 2
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  siq_msg_pkg::siq_dispatch_t                disp_i,
    input  siq_msg_pkg::siq_wakeup_t [WB_PORTS-1:0]   wakeup_i,
    input  siq_msg_pkg::siq_redirect_t                redirect_i,
    output siq_msg_pkg::siq_credit_t                  credit_o,
    output logic [siq_cfg_pkg::PREG_W-1:0]            rf_addr_preg_o,
    input  logic [siq_cfg_pkg::XLEN-1:0]              rf_addr_val_i,
    output logic [siq_cfg_pkg::PREG_W-1:0]            rf_data_preg_o,
    input  logic [siq_cfg_pkg::XLEN-1:0]              rf_data_val_i,
    output siq_msg_pkg::siq_addr_uop_t                addr_uop_o,
    output siq_msg_pkg::siq_data_uop_t                data_uop_o
);
    localparam int CNT_W = $clog2(DEPTH) + 1;
    localparam int CREDIT_W = siq_msg_pkg::CREDIT_W;

    siq_msg_pkg::siq_addr_payload_t addr_pl_in;
    siq_msg_pkg::siq_addr_payload_t addr_sel_pl;
    siq_msg_pkg::siq_addr_payload_t addr_out_pl;
    siq_msg_pkg::siq_data_payload_t data_pl_in;
    siq_msg_pkg::siq_data_payload_t data_sel_pl;
    siq_msg_pkg::siq_data_payload_t data_out_pl;

    logic                           addr_sel_valid;
    logic [siq_cfg_pkg::PREG_W-1:0] addr_sel_preg;
    siq_cfg_pkg::rob_idx_t          addr_sel_rob;
    logic                           data_sel_valid;
    logic [siq_cfg_pkg::PREG_W-1:0] data_sel_preg;
    siq_cfg_pkg::rob_idx_t          data_sel_rob;
    logic [CNT_W-1:0]               addr_freed;
    logic [CNT_W-1:0]               data_freed;
    logic                           addr_valid;
    siq_cfg_pkg::rob_idx_t          addr_rob;
    logic [siq_cfg_pkg::XLEN-1:0]   addr_base;
    logic                           data_valid;
    siq_cfg_pkg::rob_idx_t          data_rob;
    logic [siq_cfg_pkg::XLEN-1:0]   data_value;

    // each store is split into an address half and a data half.
    always_comb begin
        addr_pl_in.imm = disp_i.imm;
        addr_pl_in.sq_idx = disp_i.sq_idx;
        addr_pl_in.memop = disp_i.memop;
        data_pl_in.sq_idx = disp_i.sq_idx;
        data_pl_in.size = siq_cfg_pkg::size_of_memop(disp_i.memop);
    end

    store_entry_bank #(
        .DEPTH(DEPTH),
        .WB_PORTS(WB_PORTS),
        .payload_t(siq_msg_pkg::siq_addr_payload_t)
    ) addr_bank (
        .clk(clk),
        .rst(rst),
        .alloc_i(disp_i.valid),
        .src_preg_i(disp_i.rs1),
        .src_rdy_i(disp_i.rs1_rdy),
        .rob_i(disp_i.rob),
        .payload_i(addr_pl_in),
        .wakeup_i(wakeup_i),
        .redirect_i(redirect_i),
        .sel_valid_o(addr_sel_valid),
        .sel_preg_o(addr_sel_preg),
        .sel_rob_o(addr_sel_rob),
        .sel_payload_o(addr_sel_pl),
        .freed_cnt_o(addr_freed)
    );

    store_entry_bank #(
        .DEPTH(DEPTH),
        .WB_PORTS(WB_PORTS),
        .payload_t(siq_msg_pkg::siq_data_payload_t)
    ) data_bank (
        .clk(clk),
        .rst(rst),
        .alloc_i(disp_i.valid),
        .src_preg_i(disp_i.rs2),
        .src_rdy_i(disp_i.rs2_rdy),
        .rob_i(disp_i.rob),
        .payload_i(data_pl_in),
        .wakeup_i(wakeup_i),
        .redirect_i(redirect_i),
        .sel_valid_o(data_sel_valid),
        .sel_preg_o(data_sel_preg),
        .sel_rob_o(data_sel_rob),
        .sel_payload_o(data_sel_pl),
        .freed_cnt_o(data_freed)
    );

    store_issue_pipe #(
        .payload_t(siq_msg_pkg::siq_addr_payload_t)
    ) addr_pipe (
        .clk(clk),
        .rst(rst),
        .sel_valid_i(addr_sel_valid),
        .sel_preg_i(addr_sel_preg),
        .sel_rob_i(addr_sel_rob),
        .sel_payload_i(addr_sel_pl),
        .redirect_i(redirect_i),
        .rf_preg_o(rf_addr_preg_o),
        .rf_val_i(rf_addr_val_i),
        .valid_o(addr_valid),
        .rob_o(addr_rob),
        .val_o(addr_base),
        .payload_o(addr_out_pl)
    );

    store_issue_pipe #(
        .payload_t(siq_msg_pkg::siq_data_payload_t)
    ) data_pipe (
        .clk(clk),
        .rst(rst),
        .sel_valid_i(data_sel_valid),
        .sel_preg_i(data_sel_preg),
        .sel_rob_i(data_sel_rob),
        .sel_payload_i(data_sel_pl),
        .redirect_i(redirect_i),
        .rf_preg_o(rf_data_preg_o),
        .rf_val_i(rf_data_val_i),
        .valid_o(data_valid),
        .rob_o(data_rob),
        .val_o(data_value),
        .payload_o(data_out_pl)
    );

    always_comb begin
        addr_uop_o.valid = addr_valid;
        addr_uop_o.rob = addr_rob;
        addr_uop_o.sq_idx = addr_out_pl.sq_idx;
        addr_uop_o.base = addr_base;
        addr_uop_o.imm = addr_out_pl.imm;
        addr_uop_o.memop = addr_out_pl.memop;
        data_uop_o.valid = data_valid;
        data_uop_o.rob = data_rob;
        data_uop_o.sq_idx = data_out_pl.sq_idx;
        data_uop_o.value = data_value;
        data_uop_o.size = data_out_pl.size;
    end

    // freed entries go straight back to the dispatcher as credits.
    assign credit_o.addr_freed = CREDIT_W'(addr_freed);
    assign credit_o.data_freed = CREDIT_W'(data_freed);

endmodule

`default_nettype wire

// ==== sim/tb_store_issue_cases.svh ====
`ifndef TB_STORE_ISSUE_CASES_SVH
`define TB_STORE_ISSUE_CASES_SVH

// columns: disp rs1 rs1_rdy rs2 rs2_rdy rob sq memop imm wake0 wake1 redir redir_rob
// exp_addr exp_data. memop 0/1/2 is byte/half/word, and a zero wake column means no wakeup.
task automatic load_case_table();
    add_row(1, 10, 1, 11, 1,  1,  0, 0, 'h010,  0,  0, 0, 0, 1, 1);
    add_row(1, 12, 1, 13, 1,  2,  1, 1, 'h7f4,  0,  0, 0, 0, 1, 1);
    add_row(1, 14, 1, 15, 1,  3,  2, 2, 'h800,  0,  0, 0, 0, 1, 1);
    add_row(1, 16, 1, 40, 0,  4,  3, 2, 'h024,  0,  0, 0, 0, 1, 1);
    add_row(1, 41, 0, 17, 1,  5,  4, 0, 'h0fc,  0,  0, 0, 0, 1, 1);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000, 40, 41, 0, 0, 0, 0);
    // rob 6 is still waiting on rs2 when the redirect hits, so it must survive.
    add_row(1, 18, 1, 42, 0,  6,  5, 1, 'h100,  0,  0, 0, 0, 1, 1);
    add_row(1, 43, 0, 44, 0,  7,  6, 2, 'h200,  0,  0, 0, 0, 0, 0);
    add_row(1, 45, 0, 46, 0,  8,  7, 0, 'h204,  0,  0, 0, 0, 0, 0);
    add_row(1, 47, 0, 48, 0,  9,  8, 1, 'h208,  0,  0, 0, 0, 0, 0);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000,  0,  0, 1, 6, 0, 0);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000, 42, 43, 0, 0, 0, 0);
    // the flushed stores get their wakeups here and must stay silent.
    add_row(1, 20, 1, 21, 1,  7,  9, 2, 'habc, 44, 45, 0, 0, 1, 1);
    add_row(1, 22, 1, 23, 1,  8, 10, 0, 'h3ff, 46, 47, 0, 0, 1, 1);
    add_row(1, 24, 1, 50, 0,  9, 11, 1, 'h011, 48,  0, 0, 0, 1, 1);
    add_row(1, 25, 1, 51, 0, 10, 12, 2, 'h022,  0,  0, 0, 0, 1, 1);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000, 50, 51, 0, 0, 0, 0);
    add_row(1, 26, 1, 27, 1, 11, 13, 0, 'h055,  0,  0, 0, 0, 1, 1);
    add_row(1, 28, 1, 29, 1, 12, 14, 2, 'hfff,  0,  0, 0, 0, 1, 1);
    // rob 13 sits in the select register at the first redirect and in stage 1 at the second.
    add_row(1, 30, 1, 31, 1, 13, 15, 2, 'h030,  0,  0, 0,  0, 0, 0);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000,  0,  0, 0,  0, 0, 0);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000,  0,  0, 1, 12, 0, 0);
    add_row(1, 32, 1, 33, 1, 13, 15, 1, 'h034,  0,  0, 0,  0, 0, 0);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000,  0,  0, 0,  0, 0, 0);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000,  0,  0, 0,  0, 0, 0);
    add_row(0,  0, 0,  0, 0,  0,  0, 0, 'h000,  0,  0, 1, 12, 0, 0);
endtask

`endif

// ==== sim/tb_store_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_store_issue;

    localparam int DEPTH = 8;
    localparam int WB_PORTS = 2;
    localparam int RESET_CYCLES = 10;
    localparam int PREG_W = siq_cfg_pkg::PREG_W;
    localparam int ROB_W = siq_cfg_pkg::ROB_W;
    localparam int SQ_W = siq_cfg_pkg::SQ_W;
    localparam int SQ_N = 1 << SQ_W;
    localparam logic [31:0] RF_SEED = 32'h4ac2_c290;

    typedef struct packed {
        logic                  disp;
        logic [PREG_W-1:0]     rs1;
        logic                  rs1_rdy;
        logic [PREG_W-1:0]     rs2;
        logic                  rs2_rdy;
        siq_cfg_pkg::rob_idx_t rob;
        logic [SQ_W-1:0]       sq;
        logic [1:0]            memop;
        logic [11:0]           imm;
        logic [PREG_W-1:0]     wake0;
        logic [PREG_W-1:0]     wake1;
        logic                  redir;
        siq_cfg_pkg::rob_idx_t redir_rob;
        logic                  exp_addr;
        logic                  exp_data;
    } case_row_t;

    logic                                    clk;
    logic                                    rst;
    siq_msg_pkg::siq_dispatch_t              disp;
    siq_msg_pkg::siq_wakeup_t [WB_PORTS-1:0] wakeup;
    siq_msg_pkg::siq_redirect_t              redirect;
    siq_msg_pkg::siq_credit_t                credit;
    logic [PREG_W-1:0]                       rf_addr_preg;
    logic [PREG_W-1:0]                       rf_data_preg;
    logic [31:0]                             rf_addr_val;
    logic [31:0]                             rf_data_val;
    siq_msg_pkg::siq_addr_uop_t              addr_uop;
    siq_msg_pkg::siq_data_uop_t              data_uop;

    case_row_t         case_q [$];
    case_row_t         exp_row [SQ_N];
    logic              addr_exp [SQ_N] = '{default: 1'b0};
    logic              data_exp [SQ_N] = '{default: 1'b0};
    logic              addr_armed [SQ_N] = '{default: 1'b0};
    logic              data_armed [SQ_N] = '{default: 1'b0};
    logic [PREG_W-1:0] addr_wait [SQ_N] = '{default: '0};
    logic [PREG_W-1:0] data_wait [SQ_N] = '{default: '0};
    logic              addr_seen [SQ_N] = '{default: 1'b0};
    logic              data_seen [SQ_N] = '{default: 1'b0};
    int spent_addr = 0;
    int spent_data = 0;
    int returned_addr = 0;
    int returned_data = 0;
    int errors = 0;
    int drain_errors = 0;

    store_issue_queue #(
        .DEPTH(DEPTH),
        .WB_PORTS(WB_PORTS)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .disp_i(disp),
        .wakeup_i(wakeup),
        .redirect_i(redirect),
        .credit_o(credit),
        .rf_addr_preg_o(rf_addr_preg),
        .rf_addr_val_i(rf_addr_val),
        .rf_data_preg_o(rf_data_preg),
        .rf_data_val_i(rf_data_val),
        .addr_uop_o(addr_uop),
        .data_uop_o(data_uop)
    );

    function automatic logic [31:0] rf_value(input logic [PREG_W-1:0] p);
        return ({{(32 - PREG_W){1'b0}}, p} * 32'h0101_0101) ^ RF_SEED;
    endfunction

    // byte, halfword and word map to access sizes 0, 1 and 2.
    function automatic logic [1:0] expected_size(input logic [1:0] op);
        if (op == siq_cfg_pkg::MEMOP_SB) begin
            return 2'd0;
        end
        if (op == siq_cfg_pkg::MEMOP_SH) begin
            return 2'd1;
        end
        return 2'd2;
    endfunction

    function automatic int credits_held(input int spent, input int returned);
        return DEPTH - spent + returned;
    endfunction

    function automatic logic woken_by(input logic [PREG_W-1:0] p, input case_row_t r);
        return (r.wake0 != '0 && r.wake0 == p) || (r.wake1 != '0 && r.wake1 == p);
    endfunction

    function automatic int pending_uops();
        int n;
        n = 0;
        for (int s = 0; s < SQ_N; s++) begin
            n += int'(addr_exp[s] && !addr_seen[s]) + int'(data_exp[s] && !data_seen[s]);
        end
        return n;
    endfunction

    task automatic add_row(input int disp_v, input int rs1, input int rs1_rdy, input int rs2,
                           input int rs2_rdy, input int rob, input int sq, input int memop,
                           input int imm, input int wake0, input int wake1, input int redir,
                           input int redir_rob, input int exp_addr, input int exp_data);
        case_row_t r;
        r.disp = disp_v != 0;
        r.rs1 = PREG_W'(rs1);
        r.rs1_rdy = rs1_rdy != 0;
        r.rs2 = PREG_W'(rs2);
        r.rs2_rdy = rs2_rdy != 0;
        r.rob.dir = 1'b0;
        r.rob.idx = ROB_W'(rob);
        r.sq = SQ_W'(sq);
        r.memop = 2'(memop);
        r.imm = 12'(imm);
        r.wake0 = PREG_W'(wake0);
        r.wake1 = PREG_W'(wake1);
        r.redir = redir != 0;
        r.redir_rob.dir = 1'b0;
        r.redir_rob.idx = ROB_W'(redir_rob);
        r.exp_addr = exp_addr != 0;
        r.exp_data = exp_data != 0;
        case_q.push_back(r);
    endtask

    `include "tb_store_issue_cases.svh"

    task automatic drive_idle();
        disp <= '0;
        wakeup <= '0;
        redirect <= '0;
    endtask

    task automatic apply_row(input case_row_t r);
        siq_msg_pkg::siq_dispatch_t              d;
        siq_msg_pkg::siq_wakeup_t [WB_PORTS-1:0] w;
        siq_msg_pkg::siq_redirect_t              rd;
        @(posedge clk);
        while (r.disp && (credits_held(spent_addr, returned_addr) == 0 ||
                          credits_held(spent_data, returned_data) == 0)) begin
            drive_idle();
            @(posedge clk);
        end
        d.valid = r.disp;
        d.rs1 = r.rs1;
        d.rs1_rdy = r.rs1_rdy;
        d.rs2 = r.rs2;
        d.rs2_rdy = r.rs2_rdy;
        d.rob = r.rob;
        d.sq_idx = r.sq;
        d.memop = siq_cfg_pkg::memop_t'(r.memop);
        d.imm = r.imm;
        w[0].valid = r.wake0 != '0;
        w[0].preg = r.wake0;
        w[1].valid = r.wake1 != '0;
        w[1].preg = r.wake1;
        rd.valid = r.redir;
        rd.rob = r.redir_rob;
        disp <= d;
        wakeup <= w;
        redirect <= rd;
        if (r.disp) begin
            spent_addr++;
            spent_data++;
            exp_row[r.sq] = r;
            addr_exp[r.sq] = r.exp_addr;
            addr_armed[r.sq] = r.rs1_rdy;
            addr_wait[r.sq] = r.rs1;
            data_exp[r.sq] = r.exp_data;
            data_armed[r.sq] = r.rs2_rdy;
            data_wait[r.sq] = r.rs2;
        end
        // a uop may only show up once its operand has been woken.
        for (int s = 0; s < SQ_N; s++) begin
            if (woken_by(addr_wait[s], r)) begin
                addr_armed[s] = 1'b1;
            end
            if (woken_by(data_wait[s], r)) begin
                data_armed[s] = 1'b1;
            end
        end
    endtask

    task automatic check_addr_uop(input siq_msg_pkg::siq_addr_uop_t u);
        logic [SQ_W-1:0] s;
        case_row_t       r;
        s = u.sq_idx;
        r = exp_row[s];
        assert (addr_exp[s] && addr_armed[s] && !addr_seen[s]) else begin
            errors++;
            $display("%0t: address uop for sq %0d rob %0d was not expected at this point",
                     $time, s, u.rob.idx);
        end
        if (addr_exp[s] && !addr_seen[s]) begin
            addr_seen[s] = 1'b1;
            assert (u.base == rf_value(r.rs1) && u.imm == r.imm && u.memop == r.memop &&
                    u.rob == r.rob) else begin
                errors++;
                $display("[ERROR] %0t: addr uop sq %0d base %h imm %h op %0d, expected %h %h %0d",
                         $time, s, u.base, u.imm, u.memop, rf_value(r.rs1), r.imm, r.memop);
            end
        end
    endtask

    task automatic check_data_uop(input siq_msg_pkg::siq_data_uop_t u);
        logic [SQ_W-1:0] s;
        case_row_t       r;
        s = u.sq_idx;
        r = exp_row[s];
        assert (data_exp[s] && data_armed[s] && !data_seen[s]) else begin
            errors++;
            $display("%0t: data uop for sq %0d rob %0d was not expected at this point",
                     $time, s, u.rob.idx);
        end
        if (data_exp[s] && !data_seen[s]) begin
            data_seen[s] = 1'b1;
            assert (u.value == rf_value(r.rs2) && u.size == expected_size(r.memop) &&
                    u.rob == r.rob) else begin
                errors++;
                $display("[ERROR] %0t: data uop sq %0d value %h size %0d, expected %h %0d",
                         $time, s, u.value, u.size, rf_value(r.rs2), expected_size(r.memop));
            end
        end
    endtask

    assign rf_addr_val = rf_value(rf_addr_preg);
    assign rf_data_val = rf_value(rf_data_preg);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst) begin
            returned_addr = returned_addr + int'(credit.addr_freed);
            returned_data = returned_data + int'(credit.data_freed);
            assert (returned_addr <= spent_addr && returned_data <= spent_data) else begin
                errors++;
                $display("%0t: more credits came back than were spent", $time);
            end
            if (addr_uop.valid) begin
                check_addr_uop(addr_uop);
            end
            if (data_uop.valid) begin
                check_data_uop(data_uop);
            end
        end
    end

    initial begin
        #1;
        repeat (case_q.size() * 20 + 200 + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d table rows, the queue did not drain", case_q.size());
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        disp = '0;
        wakeup = '0;
        redirect = '0;
        load_case_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (case_q[i]) begin
            apply_row(case_q[i]);
        end
        @(posedge clk);
        drive_idle();
        while (pending_uops() != 0) begin
            @(posedge clk);
        end
        // a stray uop from a flushed store would surface within the pipeline depth.
        repeat (4) @(posedge clk);
        assert (credits_held(spent_addr, returned_addr) == DEPTH &&
                credits_held(spent_data, returned_data) == DEPTH) else begin
            drain_errors++;
            $display("[ERROR] %0t: credits after drain addr %0d data %0d, expected %0d each",
                     $time, credits_held(spent_addr, returned_addr),
                     credits_held(spent_data, returned_data), DEPTH);
        end
        $display("errors: %0d during run, %0d at drain", errors, drain_errors);
        if (errors == 0 && drain_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+sim
verilog/siq_cfg_pkg.sv
verilog/siq_msg_pkg.sv
verilog/store_entry_bank.sv
verilog/store_issue_pipe.sv
verilog/store_issue_queue.sv
sim/tb_store_issue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the store issue queue testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
    --top-module tb_store_issue -o tb_store_issue > build.log 2>&1 \
    && ./obj_dir/tb_store_issue > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
